// ==== logic/qspi_pkg.sv ====
// QSPI host shared types, bus mode encoding and per-mode lane helpers
`default_nettype none

package qspi_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  lanes_t;
    typedef logic [5:0]  beat_count_t;

    // Mode encoding of the lane block
    typedef enum logic [1:0] {
        mode_single   = 2'b00,
        mode_dual     = 2'b01,
        mode_quad     = 2'b10,
        mode_reserved = 2'b11
    } bus_mode_e;

    typedef enum logic {
        dir_write = 1'b0,
        dir_read  = 1'b1
    } xfer_dir_e;

    // One transfer request, latched by the sequencer at start
    typedef struct packed {
        bus_mode_e mode;
        xfer_dir_e dir;
        word_t     tx_word;
    } xfer_req_t;

    // Pin side of the host
    typedef struct packed {
        logic   spi_clk;
        logic   cs_n;
        lanes_t lane_out;
        lanes_t lane_oe;
    } lane_bus_t;

    // Serial clock periods needed for one 32-bit word
    function automatic beat_count_t beats_per_word(bus_mode_e mode);
        case (mode)
            mode_dual: return beat_count_t'(16);
            mode_quad: return beat_count_t'(8);
            default:   return beat_count_t'(32);
        endcase
    endfunction

    // Host driven lanes; single mode is full duplex and always drives io0
    function automatic lanes_t lane_enables(bus_mode_e mode, xfer_dir_e dir);
        case (mode)
            mode_single: return 4'b0001;
            mode_dual:   return (dir == dir_write) ? 4'b0011 : 4'b0000;
            mode_quad:   return (dir == dir_write) ? 4'b1111 : 4'b0000;
            default:     return 4'b0000;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== logic/qspi_lane_io.sv ====
// QSPI lane interface: per-mode output enables, lane drive and packed lane capture
`timescale 1ns/1ps
`default_nettype none

module qspi_lane_io
    import qspi_pkg::*;
(
    input  wire logic      sck,
    input  wire logic      rst,
    input  wire xfer_req_t cur_req,
    input  wire logic      active,
    input  wire lanes_t    tx_lanes,
    input  wire logic      sample_stb,
    input  wire lanes_t    lane_in,
    output lanes_t         lane_out,
    output lanes_t         lane_oe,
    output lanes_t         cap_lanes,
    output logic           cap_valid
);

    lanes_t oe_q;

    // Direction follows mode and dir only while a transfer runs
    always_ff @(posedge sck) begin
        if (rst) begin
            oe_q <= '0;
        end else if (active) begin
            oe_q <= lane_enables(cur_req.mode, cur_req.dir);
        end else begin
            oe_q <= '0;
        end
    end

    assign lane_oe  = oe_q;
    // Undriven lanes read as zero
    assign lane_out = tx_lanes & oe_q;

    always_ff @(posedge sck) begin
        if (rst) begin
            cap_valid <= 1'b0;
        end else begin
            cap_valid <= sample_stb;
        end
    end

    // Capture packed so the valid bits sit low, io3 stays the top quad bit
    always_ff @(posedge sck) begin
        if (sample_stb) begin
            case (cur_req.mode)
                mode_single: cap_lanes <= {3'b000, lane_in[1]};
                mode_dual:   cap_lanes <= {2'b00, lane_in[1:0]};
                mode_quad:   cap_lanes <= lane_in;
                default:     cap_lanes <= '0;
            endcase
        end
    end

    // Enables are registered, so they clear one cycle after active drops
    a_no_oe_when_idle: assert property (
        @(posedge sck) disable iff (rst) !active |=> (lane_oe == '0)
    );

endmodule

`default_nettype wire

// ==== logic/qspi_shifter.sv ====
// QSPI shift engine: transmit and receive word registers stepping 1, 2 or 4 bits per beat
`timescale 1ns/1ps
`default_nettype none

module qspi_shifter
    import qspi_pkg::*;
(
    input  wire logic      sck,
    input  wire logic      rst,
    input  wire xfer_req_t cur_req,
    input  wire logic      start_load,
    input  wire logic      drive_stb,
    input  wire logic      cap_valid,
    input  wire lanes_t    cap_lanes,
    output lanes_t         tx_lanes,
    output word_t          rx_word
);

    word_t tx_sr;
    word_t rx_sr;
    word_t tx_src;

    // First drive of a transfer takes its bits straight from the request
    assign tx_src = start_load ? cur_req.tx_word : tx_sr;

    // MSB first; in dual and quad the highest lane carries the top bit
    always_ff @(posedge sck) begin
        if (start_load || drive_stb) begin
            case (cur_req.mode)
                mode_dual: begin
                    tx_lanes <= {2'b00, tx_src[31:30]};
                    tx_sr    <= {tx_src[29:0], 2'b00};
                end
                mode_quad: begin
                    tx_lanes <= tx_src[31:28];
                    tx_sr    <= {tx_src[27:0], 4'h0};
                end
                default: begin
                    tx_lanes <= {3'b000, tx_src[31]};
                    tx_sr    <= {tx_src[30:0], 1'b0};
                end
            endcase
        end
    end

    // Receive side, one capture per beat
    always_ff @(posedge sck) begin
        if (rst) begin
            rx_sr <= '0;
        end else if (start_load) begin
            rx_sr <= '0;
        end else if (cap_valid) begin
            case (cur_req.mode)
                mode_dual: rx_sr <= {rx_sr[29:0], cap_lanes[1:0]};
                mode_quad: rx_sr <= {rx_sr[27:0], cap_lanes};
                // Single mode captures io1, packed into bit 0
                default:   rx_sr <= {rx_sr[30:0], cap_lanes[0]};
            endcase
        end
    end

    assign rx_word = rx_sr;

    // The sequencer never accepts the reserved mode, so no beat arrives with it
    a_no_reserved_capture: assert property (
        @(posedge sck) disable iff (rst) cap_valid |-> (cur_req.mode != mode_reserved)
    );

endmodule

`default_nettype wire

// ==== logic/qspi_sequencer.sv ====
// QSPI transfer sequencer: FSM, serial clock divider, chip select and beat strobes
`timescale 1ns/1ps
`default_nettype none

module qspi_sequencer
    import qspi_pkg::*;
#(
    parameter int CLK_DIV = 2
) (
    input  wire logic      sck,
    input  wire logic      rst,
    input  wire logic      start,
    input  wire xfer_req_t req,
    output xfer_req_t      cur_req,
    output logic           busy,
    output logic           done,
    output logic           drive_stb,
    output logic           sample_stb,
    output logic           spi_clk,
    output logic           cs_n
);

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_finish
    } seq_state_e;

    seq_state_e       state;
    logic [DIV_W-1:0] div_cnt;
    beat_count_t      beat_cnt;
    beat_count_t      beat_total;
    logic             lead;
    logic             accept;
    logic             tick;
    logic             last_fall;

    assign accept     = start && (state == st_idle) && (req.mode != mode_reserved);
    assign beat_total = beats_per_word(cur_req.mode);

    // Half period boundary of spi_clk
    assign tick       = (state == st_run) && !lead && (div_cnt == DIV_W'(CLK_DIV - 1));
    assign last_fall  = tick && spi_clk && (beat_cnt == beat_total);

    // Drive on the lead cycle and on every falling edge except the closing one
    assign drive_stb  = ((state == st_run) && lead) || (tick && spi_clk && !last_fall);
    assign sample_stb = tick && !spi_clk;
    assign busy       = (state != st_idle);

    // done rises 2*CLK_DIV*beats + 4 edges after the edge that launched start
    always_ff @(posedge sck) begin
        if (rst) begin
            state    <= st_idle;
            cur_req  <= '0;
            div_cnt  <= '0;
            beat_cnt <= '0;
            lead     <= 1'b0;
            spi_clk  <= 1'b0;
            cs_n     <= 1'b1;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: begin
                    if (accept) begin
                        cur_req  <= req;
                        state    <= st_run;
                        lead     <= 1'b1;
                        div_cnt  <= '0;
                        beat_cnt <= '0;
                        cs_n     <= 1'b0;
                    end
                end
                st_run: begin
                    if (lead) begin
                        // First bits go out here, divider starts next cycle
                        lead <= 1'b0;
                    end else if (tick) begin
                        div_cnt <= '0;
                        if (last_fall) begin
                            spi_clk <= 1'b0;
                            cs_n    <= 1'b1;
                            state   <= st_finish;
                        end else begin
                            spi_clk <= !spi_clk;
                            if (!spi_clk) begin
                                beat_cnt <= beat_cnt + 1'b1;
                            end
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                st_finish: begin
                    // Two cycle tail with cs_n high
                    div_cnt <= div_cnt + 1'b1;
                    if (div_cnt != '0) begin
                        done  <= 1'b1;
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    a_cs_high_in_idle: assert property (
        @(posedge sck) disable iff (rst) (state == st_idle) |-> cs_n
    );

endmodule

`default_nettype wire

// ==== logic/qspi_host.sv ====
// QSPI host top: sequencer, shift engine and lane interface for one-word transfers
`timescale 1ns/1ps
`default_nettype none

module qspi_host
    import qspi_pkg::*;
#(
    parameter int CLK_DIV = 2
) (
    input  wire logic      sck,
    input  wire logic      rst,
    input  wire logic      start,
    input  wire xfer_req_t req,
    output logic           busy,
    output logic           done,
    output word_t          rx_word,
    output logic           spi_clk,
    output logic           cs_n,
    output lanes_t         lane_out,
    output lanes_t         lane_oe,
    input  wire lanes_t    lane_in
);

    xfer_req_t cur_req;
    logic      drive_stb;
    logic      sample_stb;
    logic      start_load;
    logic      cap_valid;
    lanes_t    tx_lanes;
    lanes_t    cap_lanes;
    lane_bus_t pin_bus;

    // Only the lead drive of a transfer comes while spi_clk is low
    assign start_load = drive_stb & ~pin_bus.spi_clk;

    qspi_sequencer #(
        .CLK_DIV (CLK_DIV)
    ) u_sequencer (
        .sck        (sck),
        .rst        (rst),
        .start      (start),
        .req        (req),
        .cur_req    (cur_req),
        .busy       (busy),
        .done       (done),
        .drive_stb  (drive_stb),
        .sample_stb (sample_stb),
        .spi_clk    (pin_bus.spi_clk),
        .cs_n       (pin_bus.cs_n)
    );

    qspi_shifter u_shifter (
        .sck        (sck),
        .rst        (rst),
        .cur_req    (cur_req),
        .start_load (start_load),
        .drive_stb  (drive_stb),
        .cap_valid  (cap_valid),
        .cap_lanes  (cap_lanes),
        .tx_lanes   (tx_lanes),
        .rx_word    (rx_word)
    );

    qspi_lane_io u_lane_io (
        .sck        (sck),
        .rst        (rst),
        .cur_req    (cur_req),
        .active     (busy),
        .tx_lanes   (tx_lanes),
        .sample_stb (sample_stb),
        .lane_in    (lane_in),
        .lane_out   (pin_bus.lane_out),
        .lane_oe    (pin_bus.lane_oe),
        .cap_lanes  (cap_lanes),
        .cap_valid  (cap_valid)
    );

    assign spi_clk  = pin_bus.spi_clk;
    assign cs_n     = pin_bus.cs_n;
    assign lane_out = pin_bus.lane_out;
    assign lane_oe  = pin_bus.lane_oe;

endmodule

`default_nettype wire

// ==== verification/qspi_device_model.sv ====
// Behavioral serial device: captures written words and returns a preloaded read word
`timescale 1ns/1ps
`default_nettype none

module qspi_device_model
    import qspi_pkg::*;
(
    input  wire logic      spi_clk,
    input  wire logic      cs_n,
    input  wire bus_mode_e mode,
    input  wire xfer_dir_e dir,
    input  wire word_t     read_word,
    input  wire lanes_t    lanes,
    output lanes_t         dev_out,
    output lanes_t         dev_oe,
    output word_t          captured_word
);

    word_t out_sr = '0;
    logic  loaded = 1'b0;

    // Device drives the lanes the host leaves free
    always_comb begin
        if (cs_n) begin
            dev_oe = '0;
        end else begin
            case (mode)
                mode_single: dev_oe = 4'b0010;
                mode_dual:   dev_oe = (dir == dir_read) ? 4'b0011 : 4'b0000;
                mode_quad:   dev_oe = (dir == dir_read) ? 4'b1111 : 4'b0000;
                default:     dev_oe = 4'b0000;
            endcase
        end
    end

    // Highest used lane carries the top bit, io1 in single mode
    always_comb begin
        case (mode)
            mode_dual: dev_out = {2'b00, out_sr[31:30]};
            mode_quad: dev_out = out_sr[31:28];
            default:   dev_out = {2'b00, out_sr[31], 1'b0};
        endcase
    end

    // Load on select, then step on every falling serial clock
    always @(cs_n or negedge spi_clk) begin
        if (cs_n) begin
            loaded = 1'b0;
        end else if (!loaded) begin
            out_sr = read_word;
            loaded = 1'b1;
        end else begin
            case (mode)
                mode_dual: out_sr = out_sr << 2;
                mode_quad: out_sr = out_sr << 4;
                default:   out_sr = out_sr << 1;
            endcase
        end
    end

    // Shift in on every rising serial clock while selected
    always @(posedge spi_clk) begin
        if (!cs_n) begin
            case (mode)
                mode_dual: captured_word = {captured_word[29:0], lanes[1:0]};
                mode_quad: captured_word = {captured_word[27:0], lanes};
                default:   captured_word = {captured_word[30:0], lanes[0]};
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verification/qspi_tb.sv ====
// QSPI host testbench: directed single, dual and quad transfers against a device model
`timescale 1ns/1ps
`default_nettype none

module qspi_tb
    import qspi_pkg::*;
();

    localparam int CLK_DIV         = 2;
    localparam int CLK_PERIOD      = 100;
    localparam int XFER_LIMIT      = 2 * CLK_DIV * 32 + 10;
    // Single, two writes, two reads, reserved, busy start, three latency runs
    localparam int XFER_COUNT      = 10;
    localparam int WATCHDOG_CYCLES = 2 * XFER_COUNT * XFER_LIMIT;

    logic      sck;
    logic      rst;
    logic      start;
    xfer_req_t req;
    logic      busy;
    logic      done;
    word_t     rx_word;
    logic      spi_clk;
    logic      cs_n;
    lanes_t    lane_out;
    lanes_t    lane_oe;
    lanes_t    lane_in;
    lanes_t    dev_out;
    lanes_t    dev_oe;
    bus_mode_e dev_mode;
    xfer_dir_e dev_dir;
    word_t     dev_read_word;
    word_t     dev_captured;
    word_t     rng_state;
    int        xfer_cycles;

    always #(CLK_PERIOD / 2) sck = ~sck;

    // Pull-down bus, host enables take priority
    assign lane_in = (lane_out & lane_oe) | (dev_out & dev_oe & ~lane_oe);

    qspi_host #(
        .CLK_DIV (CLK_DIV)
    ) u_qspi_host (
        .sck      (sck),
        .rst      (rst),
        .start    (start),
        .req      (req),
        .busy     (busy),
        .done     (done),
        .rx_word  (rx_word),
        .spi_clk  (spi_clk),
        .cs_n     (cs_n),
        .lane_out (lane_out),
        .lane_oe  (lane_oe),
        .lane_in  (lane_in)
    );

    qspi_device_model u_device (
        .spi_clk       (spi_clk),
        .cs_n          (cs_n),
        .mode          (dev_mode),
        .dir           (dev_dir),
        .read_word     (dev_read_word),
        .lanes         (lane_in),
        .dev_out       (dev_out),
        .dev_oe        (dev_oe),
        .captured_word (dev_captured)
    );

    function automatic word_t next_random();
        word_t x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic int expected_beats(bus_mode_e m);
        case (m)
            mode_dual: return 16;
            mode_quad: return 8;
            default:   return 32;
        endcase
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic compare_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            fail_run($sformatf("ERR %s expected 0x%08h actual 0x%08h", name, exp, act));
        end
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("ERR %s expected %b actual %b", name, exp, act));
        end
    endtask

    // One cycle start pulse, leaves xfer_cycles at 1 after the accepting edge
    task automatic launch(input xfer_req_t r);
        dev_mode = r.mode;
        dev_dir  = r.dir;
        @(posedge sck);
        #10;
        req   = r;
        start = 1'b1;
        @(posedge sck);
        #10;
        start       = 1'b0;
        xfer_cycles = 1;
    endtask

    // Busy holds until done, then drops together with the done pulse
    task automatic wait_for_done(input string name, input logic oe_must_stay_low);
        compare_flag({name, " busy"}, 1'b1, busy);
        if (oe_must_stay_low) begin
            compare_flag({name, " lane_oe"}, 1'b0, |lane_oe);
        end
        while (!done && xfer_cycles < XFER_LIMIT) begin
            @(posedge sck);
            #10;
            xfer_cycles++;
            if (!done) begin
                compare_flag({name, " busy"}, 1'b1, busy);
            end
            if (oe_must_stay_low) begin
                compare_flag({name, " lane_oe"}, 1'b0, |lane_oe);
            end
        end
        if (!done) begin
            fail_run($sformatf("%s: no done pulse within %0d cycles", name, XFER_LIMIT));
        end else begin
            compare_flag({name, " busy at done"}, 1'b0, busy);
        end
    endtask

    task automatic check_reset_state();
        compare_flag("reset busy", 1'b0, busy);
        compare_flag("reset done", 1'b0, done);
        compare_flag("reset cs_n", 1'b1, cs_n);
        compare_flag("reset spi_clk", 1'b0, spi_clk);
        compare_flag("reset lane_oe", 1'b0, |lane_oe);
        compare_word("reset rx_word", '0, rx_word);
    endtask

    task automatic single_full_duplex();
        xfer_req_t r;
        r.mode        = mode_single;
        r.dir         = dir_write;
        r.tx_word     = next_random();
        dev_read_word = next_random();
        launch(r);
        wait_for_done("single", 1'b0);
        compare_word("single tx", r.tx_word, dev_captured);
        compare_word("single rx", dev_read_word, rx_word);
    endtask

    task automatic wide_write(input string name, input bus_mode_e m);
        xfer_req_t r;
        r.mode    = m;
        r.dir     = dir_write;
        r.tx_word = next_random();
        launch(r);
        wait_for_done(name, 1'b0);
        compare_word(name, r.tx_word, dev_captured);
    endtask

    task automatic wide_read(input string name, input bus_mode_e m);
        xfer_req_t r;
        r.mode        = m;
        r.dir         = dir_read;
        r.tx_word     = next_random();
        dev_read_word = next_random();
        launch(r);
        wait_for_done(name, 1'b1);
        compare_word(name, dev_read_word, rx_word);
    endtask

    task automatic ignored_starts();
        xfer_req_t r;
        xfer_req_t intruder;
        r.mode    = mode_reserved;
        r.dir     = dir_write;
        r.tx_word = next_random();
        launch(r);
        repeat (20) begin
            compare_flag("reserved busy", 1'b0, busy);
            compare_flag("reserved done", 1'b0, done);
            @(posedge sck);
            #10;
        end
        r.mode    = mode_quad;
        r.tx_word = next_random();
        launch(r);
        repeat (3) begin
            @(posedge sck);
            #10;
            xfer_cycles++;
        end
        // Second start lands mid transfer with a different word
        intruder.mode    = mode_dual;
        intruder.dir     = dir_write;
        intruder.tx_word = ~r.tx_word;
        req   = intruder;
        start = 1'b1;
        @(posedge sck);
        #10;
        start = 1'b0;
        xfer_cycles++;
        wait_for_done("busy start", 1'b0);
        compare_word("busy start", r.tx_word, dev_captured);
    endtask

    task automatic done_latency(input string name, input bus_mode_e m);
        xfer_req_t r;
        r.mode        = m;
        r.dir         = dir_write;
        r.tx_word     = next_random();
        dev_read_word = next_random();
        launch(r);
        wait_for_done(name, 1'b0);
        compare_word({name, " cycles"}, word_t'(2 * CLK_DIV * expected_beats(m) + 4),
                     word_t'(xfer_cycles));
        compare_flag({name, " cs_n"}, 1'b1, cs_n);
        compare_flag({name, " spi_clk"}, 1'b0, spi_clk);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run($sformatf("Watchdog expired after %0d cycles", WATCHDOG_CYCLES));
    end

    initial begin
        rng_state     = 32'ha350;
        xfer_cycles   = 0;
        sck           = 1'b0;
        rst           = 1'b1;
        start         = 1'b0;
        req           = '0;
        dev_mode      = mode_single;
        dev_dir       = dir_write;
        dev_read_word = '0;
        repeat (5) @(posedge sck);
        #10;
        rst = 1'b0;
        check_reset_state();
        single_full_duplex();
        wide_write("dual write", mode_dual);
        wide_write("quad write", mode_quad);
        wide_read("dual read", mode_dual);
        wide_read("quad read", mode_quad);
        ignored_starts();
        done_latency("single latency", mode_single);
        done_latency("dual latency", mode_dual);
        done_latency("quad latency", mode_quad);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= qspi_tb
LINT_TOP  ?= qspi_host
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qx "STATUS: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verilog.f ====
logic/qspi_pkg.sv
logic/qspi_lane_io.sv
logic/qspi_shifter.sv
logic/qspi_sequencer.sv
logic/qspi_host.sv
verification/qspi_device_model.sv
verification/qspi_tb.sv
